// ==== design/pulse_params.svh ====
`ifndef PULSE_PARAMS_SVH
`define PULSE_PARAMS_SVH

// field widths
`define PERIOD_W      24  // period counter, long enough for slow repetition rates
`define TIME_W        16  // pulse widths and delays
`define NUT_WIDTH_W   8
`define COUNT_W       8   // number of pi pulses
`define BLANK_DELAY_W 8

// power-up parameter set, a Hahn echo with blanking
`define DEF_PERIOD      2000
`define DEF_PUMP_WIDTH  30
`define DEF_PI_WIDTH    30
`define DEF_PI_DELAY    200
`define DEF_PI_COUNT    1
`define DEF_BLANK_DELAY 50
`define DEF_BLANK_WIDTH 100
`define DEF_PUMP_EN     1'b1
`define DEF_BLANK_EN    1'b1
`define DEF_NUT_EN      1'b0
`define DEF_NUT_WIDTH   50
`define DEF_NUT_DELAY   300

`endif

// ==== design/pulse_pkg.sv ====
package pulse_pkg;

`include "pulse_params.svh"

	typedef logic [`PERIOD_W-1:0]      period_t;      // period length or phase
	typedef logic [`TIME_W-1:0]        pulse_time_t;  // pulse width or delay
	typedef logic [`NUT_WIDTH_W-1:0]   nut_width_t;
	typedef logic [`COUNT_W-1:0]       pulse_count_t; // 0 = CW, 1 = Hahn, >1 = CPMG
	typedef logic [`BLANK_DELAY_W-1:0] blank_delay_t;

	// CW holds the switch open, echo covers both Hahn and CPMG
	typedef enum logic {
		MODE_CW,
		MODE_ECHO
	} seq_mode_t;

	// walk through one echo train
	typedef enum logic [1:0] {
		TR_PUMP,
		TR_GAP,
		TR_PI,
		TR_DONE
	} train_state_t;

	typedef enum logic {
		LD_IDLE,
		LD_ACK
	} load_state_t;

endpackage

// ==== design/param_loader.sv ====
`timescale 1ns/1ns

`include "pulse_params.svh"

module param_loader import pulse_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         load_req,     // host request, asynchronous to us
	input  period_t      period,
	input  pulse_time_t  pump_width,
	input  pulse_time_t  pi_delay,
	input  pulse_time_t  pi_width,
	input  pulse_time_t  nut_delay,
	input  nut_width_t   nut_width,
	input  pulse_count_t pi_count,
	input  blank_delay_t blank_delay,
	input  pulse_time_t  blank_width,
	input  logic         pump_en,
	input  logic         nut_en,
	input  logic         blank_en,
	input  logic         period_start, // last cycle of the period, active set swaps here
	output logic         load_ack,
	output period_t      act_period,
	output pulse_time_t  act_pump_width,
	output pulse_time_t  act_pi_delay,
	output pulse_time_t  act_pi_width,
	output pulse_time_t  act_nut_delay,
	output nut_width_t   act_nut_width,
	output pulse_count_t act_pi_count,
	output blank_delay_t act_blank_delay,
	output pulse_time_t  act_blank_width,
	output logic         act_pump_en,
	output logic         act_nut_en,
	output logic         act_blank_en
);
	load_state_t  ld_state;
	logic         req_s1;   // two flop synchroniser on load_req
	logic         req_s2;
	logic         pending;  // shadow set captured but not yet applied
	logic         capture;

	period_t      sh_period;
	pulse_time_t  sh_pump_width;
	pulse_time_t  sh_pi_delay;
	pulse_time_t  sh_pi_width;
	pulse_time_t  sh_nut_delay;
	nut_width_t   sh_nut_width;
	pulse_count_t sh_pi_count;
	blank_delay_t sh_blank_delay;
	pulse_time_t  sh_blank_width;
	logic         sh_pump_en;
	logic         sh_nut_en;
	logic         sh_blank_en;

	assign capture  = (ld_state == LD_IDLE) && req_s2;
	assign load_ack = (ld_state == LD_ACK);  // state decode, so ack comes straight off a flop

	// handshake side
	always_ff @(posedge clk) begin
		if (reset) begin
			req_s1   <= 1'b0;
			req_s2   <= 1'b0;
			ld_state <= LD_IDLE;
		end else begin
			req_s1 <= load_req;
			req_s2 <= req_s1;
			case (ld_state)
				LD_IDLE: begin
					if (req_s2) begin
						ld_state <= LD_ACK;
					end
				end
				default: begin
					if (!req_s2) begin  // host dropped req, release ack
						ld_state <= LD_IDLE;
					end
				end
			endcase
		end
	end

	// host data is stable while req is up
	always_ff @(posedge clk) begin
		if (capture) begin
			sh_period      <= period;
			sh_pump_width  <= pump_width;
			sh_pi_delay    <= pi_delay;
			sh_pi_width    <= pi_width;
			sh_nut_delay   <= nut_delay;
			sh_nut_width   <= nut_width;
			sh_pi_count    <= pi_count;
			sh_blank_delay <= blank_delay;
			sh_blank_width <= blank_width;
			sh_pump_en     <= pump_en;
			sh_nut_en      <= nut_en;
			sh_blank_en    <= blank_en;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending         <= 1'b0;
			act_period      <= period_t'(`DEF_PERIOD);
			act_pump_width  <= pulse_time_t'(`DEF_PUMP_WIDTH);
			act_pi_delay    <= pulse_time_t'(`DEF_PI_DELAY);
			act_pi_width    <= pulse_time_t'(`DEF_PI_WIDTH);
			act_nut_delay   <= pulse_time_t'(`DEF_NUT_DELAY);
			act_nut_width   <= nut_width_t'(`DEF_NUT_WIDTH);
			act_pi_count    <= pulse_count_t'(`DEF_PI_COUNT);
			act_blank_delay <= blank_delay_t'(`DEF_BLANK_DELAY);
			act_blank_width <= pulse_time_t'(`DEF_BLANK_WIDTH);
			act_pump_en     <= `DEF_PUMP_EN;
			act_nut_en      <= `DEF_NUT_EN;
			act_blank_en    <= `DEF_BLANK_EN;
		end else begin
			if (period_start && pending) begin  // new set is live from phase 0 on
				act_period      <= sh_period;
				act_pump_width  <= sh_pump_width;
				act_pi_delay    <= sh_pi_delay;
				act_pi_width    <= sh_pi_width;
				act_nut_delay   <= sh_nut_delay;
				act_nut_width   <= sh_nut_width;
				act_pi_count    <= sh_pi_count;
				act_blank_delay <= sh_blank_delay;
				act_blank_width <= sh_blank_width;
				act_pump_en     <= sh_pump_en;
				act_nut_en      <= sh_nut_en;
				act_blank_en    <= sh_blank_en;
			end
			// a capture on the swap edge waits for the following period
			if (capture) begin
				pending <= 1'b1;
			end else if (period_start) begin
				pending <= 1'b0;
			end
		end
	end

endmodule

// ==== design/period_timer.sv ====
`timescale 1ns/1ns

module period_timer import pulse_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  period_t period,        // last phase value, period lasts period+1 cycles
	output period_t phase,
	output logic    period_start   // high on the cycle before phase returns to 0
);

	// >= so a shrunk period can never leave the counter running away
	assign period_start = (phase >= period);

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= '0;
		end else if (period_start) begin
			phase <= '0;  // wrap
		end else begin
			phase <= phase + 1'b1;
		end
	end

endmodule

// ==== design/echo_sequencer.sv ====
`timescale 1ns/1ns

module echo_sequencer import pulse_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  period_t      phase,
	input  pulse_time_t  pump_width,   // P
	input  pulse_time_t  pi_delay,     // D
	input  pulse_time_t  pi_width,     // W
	input  blank_delay_t blank_delay,  // pi end to blank window start
	input  pulse_time_t  blank_width,  // length of the receive window
	input  pulse_count_t pi_count,     // n, 0 selects CW
	input  logic         pump_en,
	input  logic         blank_en,
	output logic         seq_pulse,
	output logic         seq_sync,
	output logic         seq_inhib
);
	seq_mode_t    mode;
	train_state_t state;
	pulse_count_t pi_idx;       // pi pulse the start/end registers point at
	pulse_count_t blk_idx;      // pi pulse the blank registers point at
	pulse_count_t last_idx;
	logic         blk_run;      // blank windows still to come this period

	period_t      pi_start;     // running next-edge registers
	period_t      pi_end;
	period_t      blk_start;
	period_t      blk_end;

	period_t      pump_end;
	period_t      step;         // W + 2D between pi pulses
	period_t      first_start;
	period_t      first_end;
	period_t      first_blk_start;
	period_t      first_blk_end;

	logic         pump_hit;
	logic         pi_hit;
	logic         blk_hit;
	logic         pi_done;      // current pi pulse ends this cycle
	logic         blk_done;
	logic         at_last_end;
	logic         pulse_nx;
	logic         sync_nx;
	logic         inhib_nx;

	assign mode     = (pi_count == '0) ? MODE_CW : MODE_ECHO;
	assign last_idx = pi_count - 1'b1;

	// edges of the first pi pulse, later ones are stepped from these
	assign pump_end        = period_t'(pump_width);
	assign step            = period_t'(pi_width) + (period_t'(pi_delay) << 1);
	assign first_start     = pump_end + period_t'(pi_delay);
	assign first_end       = first_start + period_t'(pi_width);
	assign first_blk_start = first_end + period_t'(blank_delay);
	assign first_blk_end   = first_blk_start + period_t'(blank_width);

	assign pump_hit    = (state == TR_PUMP) && pump_en && (phase < pump_end);
	assign pi_hit      = (state != TR_DONE) && (phase >= pi_start) && (phase < pi_end);
	assign blk_hit     = blk_run && (phase >= blk_start) && (phase < blk_end);
	assign pi_done     = (state != TR_DONE) && (phase == pi_end);
	assign blk_done    = blk_run && (phase == blk_end);
	assign at_last_end = pi_done && (pi_idx == last_idx);  // sync drops here

	always_comb begin
		if (mode == MODE_CW) begin
			pulse_nx = 1'b1;  // switch held open
			sync_nx  = 1'b0;
			inhib_nx = 1'b0;
		end else if (phase == '0) begin
			// edge registers reload on this cycle and are stale here
			pulse_nx = pump_en && (pump_width != '0);
			sync_nx  = 1'b1;
			inhib_nx = blank_en;
		end else begin
			pulse_nx = pump_hit || pi_hit;
			sync_nx  = (state != TR_DONE) && !at_last_end;
			inhib_nx = blank_en && !blk_hit;  // open the receiver only in the window
		end
	end

	// train FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= TR_DONE;
			pi_idx  <= '0;
			blk_idx <= '0;
			blk_run <= 1'b0;
		end else if (phase == '0) begin
			state   <= (mode == MODE_ECHO) ? TR_PUMP : TR_DONE;
			pi_idx  <= '0;
			blk_idx <= '0;
			blk_run <= (mode == MODE_ECHO);
		end else begin
			if (pi_done) begin
				pi_idx <= pi_idx + 1'b1;
				state  <= at_last_end ? TR_DONE : TR_GAP;
			end else begin
				case (state)
					TR_PUMP: begin
						if (phase >= pump_end) begin
							state <= TR_GAP;
						end
					end
					TR_GAP: begin
						if (phase >= pi_start) begin  // pi pulse starts
							state <= TR_PI;
						end
					end
					default: begin
						state <= state;  // TR_PI left through pi_done, TR_DONE waits for phase 0
					end
				endcase
			end
			if (blk_done) begin
				blk_idx <= blk_idx + 1'b1;
				blk_run <= (blk_idx != last_idx);
			end
		end
	end

	// next-edge registers, guarded by state and blk_run
	always_ff @(posedge clk) begin
		if (phase == '0) begin
			pi_start  <= first_start;
			pi_end    <= first_end;
			blk_start <= first_blk_start;
			blk_end   <= first_blk_end;
		end else begin
			if (pi_done) begin
				pi_start <= pi_start + step;
				pi_end   <= pi_end + step;
			end
			if (blk_done) begin
				blk_start <= blk_start + step;
				blk_end   <= blk_end + step;
			end
		end
	end

	// first of the two output register stages
	always_ff @(posedge clk) begin
		if (reset) begin
			seq_pulse <= 1'b0;
			seq_sync  <= 1'b0;
			seq_inhib <= 1'b0;
		end else begin
			seq_pulse <= pulse_nx;
			seq_sync  <= sync_nx;
			seq_inhib <= inhib_nx;
		end
	end

endmodule

// ==== design/nutation_gate.sv ====
`timescale 1ns/1ns

module nutation_gate import pulse_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  period_t     phase,
	input  period_t     period,
	input  logic        nut_en,
	input  pulse_time_t nut_delay,  // window end, counted back from the period end
	input  nut_width_t  nut_width,
	input  logic        seq_pulse,  // already one cycle behind phase
	input  logic        seq_sync,
	input  logic        seq_inhib,
	output logic        pulse_on,
	output logic        sync_on,
	output logic        inhib
);
	period_t nut_start;
	period_t nut_stop;
	logic    nut_win;   // lines up with the seq_* register stage

	// window sits near the period end so the one cycle lag after a swap is harmless
	always_ff @(posedge clk) begin
		nut_start <= period - period_t'(nut_delay) - period_t'(nut_width);
		nut_stop  <= period - period_t'(nut_delay);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			nut_win  <= 1'b0;
			pulse_on <= 1'b0;
			sync_on  <= 1'b0;
			inhib    <= 1'b0;
		end else begin
			nut_win  <= nut_en && (phase >= nut_start) && (phase < nut_stop);
			pulse_on <= seq_pulse || nut_win;  // merge into the switch gate
			sync_on  <= seq_sync;
			inhib    <= seq_inhib;
		end
	end

endmodule

// ==== design/pulse_top.sv ====
`timescale 1ns/1ns

module pulse_top import pulse_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         load_req,
	output logic         load_ack,
	input  period_t      period,
	input  pulse_time_t  pump_width,
	input  pulse_time_t  pi_delay,
	input  pulse_time_t  pi_width,
	input  pulse_time_t  nut_delay,
	input  nut_width_t   nut_width,
	input  pulse_count_t pi_count,
	input  blank_delay_t blank_delay,
	input  pulse_time_t  blank_width,
	input  logic         pump_en,
	input  logic         nut_en,
	input  logic         blank_en,
	output logic         sync_on,   // scope trigger
	output logic         pulse_on,  // microwave switch gate
	output logic         inhib      // receiver blanking
);
	// active parameter set
	period_t      act_period;
	pulse_time_t  act_pump_width;
	pulse_time_t  act_pi_delay;
	pulse_time_t  act_pi_width;
	pulse_time_t  act_nut_delay;
	nut_width_t   act_nut_width;
	pulse_count_t act_pi_count;
	blank_delay_t act_blank_delay;
	pulse_time_t  act_blank_width;
	logic         act_pump_en;
	logic         act_nut_en;
	logic         act_blank_en;

	period_t      phase;
	logic         period_start;
	logic         seq_pulse;
	logic         seq_sync;
	logic         seq_inhib;

	param_loader u_loader (
		.clk(clk),
		.reset(reset),
		.load_req(load_req),
		.period(period),
		.pump_width(pump_width),
		.pi_delay(pi_delay),
		.pi_width(pi_width),
		.nut_delay(nut_delay),
		.nut_width(nut_width),
		.pi_count(pi_count),
		.blank_delay(blank_delay),
		.blank_width(blank_width),
		.pump_en(pump_en),
		.nut_en(nut_en),
		.blank_en(blank_en),
		.period_start(period_start),
		.load_ack(load_ack),
		.act_period(act_period),
		.act_pump_width(act_pump_width),
		.act_pi_delay(act_pi_delay),
		.act_pi_width(act_pi_width),
		.act_nut_delay(act_nut_delay),
		.act_nut_width(act_nut_width),
		.act_pi_count(act_pi_count),
		.act_blank_delay(act_blank_delay),
		.act_blank_width(act_blank_width),
		.act_pump_en(act_pump_en),
		.act_nut_en(act_nut_en),
		.act_blank_en(act_blank_en)
	);

	period_timer u_timer (
		.clk(clk),
		.reset(reset),
		.period(act_period),
		.phase(phase),
		.period_start(period_start)
	);

	echo_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.phase(phase),
		.pump_width(act_pump_width),
		.pi_delay(act_pi_delay),
		.pi_width(act_pi_width),
		.blank_delay(act_blank_delay),
		.blank_width(act_blank_width),
		.pi_count(act_pi_count),
		.pump_en(act_pump_en),
		.blank_en(act_blank_en),
		.seq_pulse(seq_pulse),
		.seq_sync(seq_sync),
		.seq_inhib(seq_inhib)
	);

	nutation_gate u_gate (
		.clk(clk),
		.reset(reset),
		.phase(phase),
		.period(act_period),
		.nut_en(act_nut_en),
		.nut_delay(act_nut_delay),
		.nut_width(act_nut_width),
		.seq_pulse(seq_pulse),
		.seq_sync(seq_sync),
		.seq_inhib(seq_inhib),
		.pulse_on(pulse_on),
		.sync_on(sync_on),
		.inhib(inhib)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// 40 ns period
	always begin
		#20 clk = ~clk;
	end

endmodule

// ==== verification/pulse_tb.sv ====
`timescale 1ns/1ns

`include "pulse_params.svh"

module pulse_tb import pulse_pkg::*; ();
	localparam int WAIT_LIMIT = 10000;  // cycles, well above the longest period used
	localparam int SEL_PULSE  = 0;
	localparam int SEL_INHIB  = 1;
	localparam int SEL_SYNC   = 2;

	logic         clk;
	logic         reset;
	logic         load_req;
	logic         load_ack;
	period_t      period;
	pulse_time_t  pump_width;
	pulse_time_t  pi_delay;
	pulse_time_t  pi_width;
	pulse_time_t  nut_delay;
	nut_width_t   nut_width;
	pulse_count_t pi_count;
	blank_delay_t blank_delay;
	pulse_time_t  blank_width;
	logic         pump_en;
	logic         nut_en;
	logic         blank_en;
	logic         sync_on;
	logic         pulse_on;
	logic         inhib;

	tb_clock_gen u_clk (
		.clk(clk)
	);

	pulse_top dut (.*);

	// outputs are sampled on the falling edge, half a cycle after they change
	function automatic logic pick(input int sel);
		case (sel)
			SEL_PULSE: pick = pulse_on;
			SEL_INHIB: pick = inhib;
			default:   pick = sync_on;
		endcase
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_time(input string name, input pulse_time_t got, input pulse_time_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_period(input string name, input period_t got, input period_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_idle_outputs();
		check_bit("sync_on", sync_on, 1'b0);
		check_bit("pulse_on", pulse_on, 1'b0);
		check_bit("inhib", inhib, 1'b0);
		check_bit("load_ack", load_ack, 1'b0);
	endtask

	// n returns the number of cycles until the rise
	task automatic wait_sync_rise(output int n);
		logic prev;
		logic seen;
		prev = sync_on;  // a level that is already high is not a rise
		seen = 1'b0;
		n    = 0;
		while (!seen && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
			seen = sync_on && !prev;
			prev = sync_on;
		end
		if (!seen) begin
			abort_run("timed out waiting for sync_on to rise");
		end
	endtask

	task automatic wait_for(input int sel, input logic level, input string what);
		int n;
		n = 0;
		while (pick(sel) !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (pick(sel) !== level) begin
			abort_run({"timed out waiting for ", what});
		end
	endtask

	// nth high run of an output within one period, offsets counted from the sync_on rise
	task automatic measure_high(input int sel, input logic invert, input int nth,
			input int limit, output pulse_time_t offset, output pulse_time_t width);
		int   n;
		int   t;
		int   runs;
		logic lvl;
		logic prev;
		logic in_run;
		logic done;
		wait_sync_rise(n);
		offset = '0;
		width  = '0;  // stays 0 when there is no such run
		runs   = 0;
		prev   = 1'b0;
		in_run = 1'b0;
		done   = 1'b0;
		for (t = 0; t <= limit && !done; t++) begin
			if (t > 0) begin
				@(negedge clk);
			end
			lvl = pick(sel) ^ invert;  // invert turns the inhib windows into high runs
			if (lvl && !prev) begin
				in_run = (runs == nth);
				if (in_run) begin
					offset = pulse_time_t'(t);
				end
				runs++;
			end
			if (in_run && lvl) begin
				width = width + 1'b1;
			end else if (in_run) begin
				done = 1'b1;  // run is over
			end
			prev = lvl;
		end
	endtask

	task automatic expect_pulse(input string name, input int sel, input logic invert,
			input int nth, input int exp_off, input int exp_wid);
		pulse_time_t off;
		pulse_time_t wid;
		measure_high(sel, invert, nth, int'(period), off, wid);
		check_time({name, " offset"}, off, pulse_time_t'(exp_off));
		check_time({name, " width"}, wid, pulse_time_t'(exp_wid));
	endtask

	// width of the next high run, from wherever we are now
	task automatic next_high_width(input int sel, output pulse_time_t width);
		int n;
		wait_for(sel, 1'b1, "the next pulse");
		width = '0;
		n     = 0;
		while (pick(sel) === 1'b1 && n < WAIT_LIMIT) begin
			width = width + 1'b1;
			@(negedge clk);
			n++;
		end
		if (pick(sel) === 1'b1) begin
			abort_run("timed out waiting for a pulse to end");
		end
	endtask

	task automatic check_steady(input string name, input int sel, input logic exp,
			input int cycles);
		int t;
		for (t = 0; t < cycles; t++) begin
			@(negedge clk);
			check_bit(name, pick(sel), exp);
		end
	endtask

	task automatic set_echo(input period_t per, input pulse_time_t p, input pulse_time_t d,
			input pulse_time_t w, input pulse_count_t n, input blank_delay_t bd,
			input pulse_time_t bw, input logic pe, input logic be);
		@(posedge clk);
		period      <= per;
		pump_width  <= p;
		pi_delay    <= d;
		pi_width    <= w;
		pi_count    <= n;
		blank_delay <= bd;
		blank_width <= bw;
		pump_en     <= pe;
		blank_en    <= be;
	endtask

	task automatic set_nutation(input logic en, input pulse_time_t dly, input nut_width_t wid);
		@(posedge clk);
		nut_en    <= en;
		nut_delay <= dly;
		nut_width <= wid;
	endtask

	// four phase handshake, data already sits on the ports
	task automatic load_params();
		int n;
		@(posedge clk);
		load_req <= 1'b1;
		@(negedge clk);
		check_bit("load_ack", load_ack, 1'b0);  // synchroniser has not seen req yet
		n = 0;
		while (load_ack !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (load_ack !== 1'b1) begin
			abort_run("timed out waiting for load_ack to rise");
		end
		check_time("load_ack rise latency", pulse_time_t'(n), pulse_time_t'(3));
		@(posedge clk);
		load_req <= 1'b0;
		@(negedge clk);
		check_bit("load_ack", load_ack, 1'b1);  // held until the drop gets through
		n = 0;
		while (load_ack !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (load_ack !== 1'b0) begin
			abort_run("timed out waiting for load_ack to fall");
		end
		check_time("load_ack fall latency", pulse_time_t'(n), pulse_time_t'(3));
	endtask

	// whole echo train expected from the parameters on the ports, one period per check
	task automatic check_echo_train();
		int k;
		int n;
		int first;  // pulse_on run that holds pi pulse 0
		int step;   // W + 2D
		int pi_at;
		int sync_len;
		step     = int'(pi_width) + 2 * int'(pi_delay);
		first    = pump_en ? 1 : 0;
		sync_len = int'(pump_width) + int'(pi_delay) + (int'(pi_count) - 1) * step
			+ int'(pi_width);
		if (pump_en) begin
			expect_pulse("pulse_on", SEL_PULSE, 1'b0, 0, 0, int'(pump_width));
		end
		for (k = 0; k < int'(pi_count); k++) begin
			pi_at = int'(pump_width) + int'(pi_delay) + k * step;
			expect_pulse("pulse_on", SEL_PULSE, 1'b0, first + k, pi_at, int'(pi_width));
			if (blank_en) begin
				expect_pulse("inhib", SEL_INHIB, 1'b1, k,
					pi_at + int'(pi_width) + int'(blank_delay), int'(blank_width));
			end
		end
		expect_pulse("sync_on", SEL_SYNC, 1'b0, 0, 0, sync_len);  // drops at the last pi end
		if (nut_en) begin
			expect_pulse("pulse_on", SEL_PULSE, 1'b0, first + int'(pi_count),
				int'(period) - int'(nut_delay) - int'(nut_width), int'(nut_width));
		end else begin
			expect_pulse("pulse_on", SEL_PULSE, 1'b0, first + int'(pi_count), 0, 0);
		end
		if (!blank_en) begin
			wait_sync_rise(n);
			check_steady("inhib", SEL_INHIB, 1'b0, int'(period));
		end
	endtask

	task automatic test_reset_defaults();
		int i;
		for (i = 0; i < 3; i++) begin
			@(posedge clk);
			if (i == 2) begin
				reset <= 1'b0;  // third edge still sees reset
			end
			@(negedge clk);
			check_idle_outputs();
		end
		@(negedge clk);  // first cycle out of reset
		check_idle_outputs();
		check_echo_train();  // power-up Hahn set
	endtask

	task automatic test_load_handshake();
		int          n;
		pulse_time_t wid;
		wait_sync_rise(n);
		wait_for(SEL_PULSE, 1'b0, "the pump pulse to end");
		set_echo(period_t'(1500), 30, 200, 40, 1, 50, 100, 1'b1, 1'b1);
		load_params();
		next_high_width(SEL_PULSE, wid);
		check_time("pulse_on width", wid, pulse_time_t'(`DEF_PI_WIDTH));  // old set this period
		expect_pulse("pulse_on", SEL_PULSE, 1'b0, 1, int'(pump_width) + int'(pi_delay),
			int'(pi_width));
	endtask

	task automatic test_hahn();
		set_echo(period_t'(1200), 20, 80, 16, 1, 12, 60, 1'b1, 1'b1);
		load_params();
		check_echo_train();
	endtask

	task automatic test_cpmg();
		set_echo(period_t'(1000), 20, 40, 12, 3, 8, 30, 1'b1, 1'b1);
		load_params();
		check_echo_train();
		set_echo(period_t'(1000), 20, 40, 12, 3, 8, 30, 1'b0, 1'b0);  // no pump, no blanking
		load_params();
		check_echo_train();
	endtask

	task automatic test_cw();
		int n;
		int t;
		set_echo(period_t'(400), 20, 40, 12, 0, 8, 30, 1'b1, 1'b1);
		load_params();
		// switch open with no scope trigger only happens in CW
		n = 0;
		while (!(pulse_on === 1'b1 && sync_on === 1'b0) && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!(pulse_on === 1'b1 && sync_on === 1'b0)) begin
			abort_run("timed out waiting for CW mode to start");
		end
		for (t = 0; t < 2 * (int'(period) + 1); t++) begin
			check_bit("pulse_on", pulse_on, 1'b1);
			check_bit("sync_on", sync_on, 1'b0);
			check_bit("inhib", inhib, 1'b0);
			@(negedge clk);
		end
	endtask

	task automatic test_nutation();
		int n;
		set_echo(period_t'(1000), 20, 60, 16, 1, 10, 40, 1'b1, 1'b1);
		set_nutation(1'b1, 100, 30);
		load_params();
		check_echo_train();  // nutation window shows up as the last pulse_on run
		wait_sync_rise(n);
		wait_sync_rise(n);
		check_period("sync_on spacing", period_t'(n), period + 1'b1);
	endtask

	initial begin
		reset       = 1'b1;
		load_req    = 1'b0;
		period      = period_t'(`DEF_PERIOD);
		pump_width  = pulse_time_t'(`DEF_PUMP_WIDTH);
		pi_delay    = pulse_time_t'(`DEF_PI_DELAY);
		pi_width    = pulse_time_t'(`DEF_PI_WIDTH);
		pi_count    = pulse_count_t'(`DEF_PI_COUNT);
		blank_delay = blank_delay_t'(`DEF_BLANK_DELAY);
		blank_width = pulse_time_t'(`DEF_BLANK_WIDTH);
		pump_en     = `DEF_PUMP_EN;
		blank_en    = `DEF_BLANK_EN;
		nut_en      = `DEF_NUT_EN;
		nut_delay   = pulse_time_t'(`DEF_NUT_DELAY);
		nut_width   = nut_width_t'(`DEF_NUT_WIDTH);
		test_reset_defaults();
		test_load_handshake();
		test_hahn();
		test_cpmg();
		test_cw();
		test_nutation();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+design
design/pulse_pkg.sv
design/param_loader.sv
design/period_timer.sv
design/echo_sequencer.sv
design/nutation_gate.sv
design/pulse_top.sv
verification/tb_clock_gen.sv
verification/pulse_tb.sv

// ==== Bender.yml ====
package:
  name: pulse_sequencer

export_include_dirs:
  - design

sources:
  - design/pulse_pkg.sv
  - design/param_loader.sv
  - design/period_timer.sv
  - design/echo_sequencer.sv
  - design/nutation_gate.sv
  - design/pulse_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/pulse_tb.sv
